// ==== verification/ifmap_vectors.txt ====
// cmd(2) arg(2) data(16): 01 layer+start, 02 packet mask/bytes lane0 rightmost, 03 free
// 04 probe byte/row/elem, 05 expect image, 06 stall on/off, 07 hold check, 08 fill n from byte
01000000000000000002
02ff0807060504030201
02ff100f0e0d0c0b0a09
02ff1817161514131211
05000000000000000000
04180000000000000305
02ff2827262524232221
020f3c3b3a3934333231
02f04847464544434241
02aa5857565554535251
02556867666564636261
03000000000000000000
05000000000000000000
04340000000000000105
06000000000000000001
01000000000000000002
08030000000000000001
05000000000000000000
02ff2827262524232221
020f3c3b3a3934333231
02f04847464544434241
02aa5857565554535251
02556867666564636261
03000000000000000000
05000000000000000000
01000000000000000001
080c0000000000000001
05000000000000000000
08090000000000000080
07000000000000000000
03000000000000000000
05000000000000000000
0460000000000000010b
04800000000000000200

// ==== sources.f ====
+incdir+hdl
hdl/ifmap_pkg.sv
hdl/packet_decoder.sv
hdl/bank_store.sv
hdl/bank_sequencer.sv
hdl/ifmap_buffer.sv
verification/ifmap_buffer_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -Wno-fatal --top-module ifmap_buffer_tb \
    -f sources.f -o ifmap_sim > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/ifmap_sim > sim.log 2>&1
grep -q "^Verification passed$" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

// ==== verification/ifmap_buffer_tb.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ifmap_config.svh"

module ifmap_buffer_tb import ifmap_pkg::*; ();

    localparam int CLK_PERIOD  = 40;
    localparam int MAX_LINES   = 128;
    localparam int LINE_CYCLES = 400;

    logic         clk;
    logic         rst_n;
    logic         start;
    logic         start_layer;
    layer_type_t  layer_type_in;
    fifo_packet_t packet;
    logic         decompressor_ack;
    logic         free_ifmap_buffer;
    logic         ifmap_buffer_req;
    ifmap_image_t ifmap_data;
    logic         ifmap_data_valid;
    logic         ifmap_data_change;

    logic [79:0]  vec [0:MAX_LINES-1];
    int           nlines;
    logic         loaded;
    integer       seed;
    logic         stall_en;

    // reference model state for the image being filled and the completed ones
    ifmap_image_t ref_img;
    ifmap_image_t ref_done [$];
    ifmap_image_t last_img;
    int           ref_row;
    int           ref_elem;
    int           ref_rows;
    int           ref_elems;
    int           ref_ovl;

    ifmap_buffer ifmap_buffer_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .start_layer       (start_layer),
        .layer_type_in     (layer_type_in),
        .packet            (packet),
        .decompressor_ack  (decompressor_ack),
        .free_ifmap_buffer (free_ifmap_buffer),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .ifmap_data        (ifmap_data),
        .ifmap_data_valid  (ifmap_data_valid),
        .ifmap_data_change (ifmap_data_change)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic stop_run();
        $display("Verification failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_image(input string name, input ifmap_image_t got,
                               input ifmap_image_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_run();
        end
    endtask

    task automatic check_byte(input string name, input logic [`IFB_ELEM_W-1:0] got,
                              input logic [`IFB_ELEM_W-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic next_ack();
        if (!stall_en) begin
            return 1'b1;
        end
        return (($random(seed) & 3) != 0);
    endfunction

    // valid lanes go in lane order and a full bank takes no more lanes
    task automatic model_packet(input fifo_packet_t pkt);
        ifmap_image_t nxt;
        for (int i = 0; i < `IFB_LANES; i++) begin
            if (pkt.valid_mask[i] && ref_row < ref_rows) begin
                ref_img[ref_row][ref_elem] = pkt.data[i];
                ref_elem++;
                if (ref_elem == ref_elems) begin
                    ref_elem = 0;
                    ref_row++;
                end
            end
        end
        if (ref_row == ref_rows) begin
            ref_done.push_back(ref_img);
            // next image opens with the last overlap rows of this one
            nxt = '0;
            for (int r = 0; r < ref_ovl; r++) begin
                nxt[r] = ref_img[ref_rows-ref_ovl+r];
            end
            ref_img  = nxt;
            ref_row  = ref_ovl;
            ref_elem = 0;
        end
    endtask

    task automatic send_packet(input fifo_packet_t pkt);
        logic done;
        done = 1'b0;
        @(posedge clk);
        packet           <= pkt;
        decompressor_ack <= next_ack();
        while (!done) begin
            @(negedge clk);
            if (ifmap_buffer_req && decompressor_ack) begin
                done = 1'b1;
            end else begin
                @(posedge clk);
                decompressor_ack <= next_ack();
            end
        end
        @(posedge clk);
        packet           <= '0;
        decompressor_ack <= 1'b0;
        model_packet(pkt);
    endtask

    task automatic load_layer(input layer_type_t lt);
        @(posedge clk);
        layer_type_in <= lt;
        start_layer   <= 1'b1;
        @(posedge clk);
        start_layer <= 1'b0;
        start       <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        ref_rows  = (lt == LAYER_CONV1) ? `IFB_CONV1_ROWS : `IFB_CONV2_ROWS;
        ref_elems = (lt == LAYER_CONV1) ? `IFB_CONV1_ELEMS : `IFB_CONV2_ELEMS;
        ref_ovl   = (lt == LAYER_CONV1) ? `IFB_CONV1_OVERLAP : `IFB_CONV2_OVERLAP;
        ref_img   = '0;
        ref_row   = 0;
        ref_elem  = 0;
        ref_done.delete();
    endtask

    task automatic expect_image();
        do begin
            @(negedge clk);
        end while (!ifmap_data_change);
        if (ref_done.size() == 0) begin
            $display("image offered by the DUT but the reference has none complete");
            stop_run();
        end
        last_img = ref_done.pop_front();
        check_flag("ifmap_data_valid", ifmap_data_valid, 1'b1);
        check_image("ifmap_data", ifmap_data, last_img);
        @(negedge clk);
        check_flag("ifmap_data_change", ifmap_data_change, 1'b0);
    endtask

    task automatic run_line(input logic [79:0] v);
        fifo_packet_t           pkt;
        logic [`IFB_ELEM_W-1:0] b;
        case (v[79:72])
            8'h01: load_layer(layer_type_t'(v[1:0]));
            8'h02: begin
                pkt.packet_valid = 1'b1;
                pkt.valid_mask   = v[71:64];
                pkt.data         = v[63:0];
                send_packet(pkt);
            end
            8'h03: begin
                @(posedge clk);
                free_ifmap_buffer <= 1'b1;
                @(posedge clk);
                free_ifmap_buffer <= 1'b0;
            end
            8'h04: check_byte($sformatf("ifmap_data[%0d][%0d]", v[15:8], v[7:0]),
                              ifmap_data[v[15:8]][v[7:0]], v[71:64]);
            8'h05: expect_image();
            8'h06: stall_en = v[0];
            8'h07: begin
                // with both banks full the read image holds and input stalls
                repeat (4) begin
                    @(negedge clk);
                    check_flag("ifmap_buffer_req", ifmap_buffer_req, 1'b0);
                    check_flag("ifmap_data_valid", ifmap_data_valid, 1'b1);
                    check_flag("ifmap_data_change", ifmap_data_change, 1'b0);
                    check_image("ifmap_data", ifmap_data, last_img);
                end
            end
            8'h08: begin
                b = v[7:0];
                for (int p = 0; p < v[71:64]; p++) begin
                    pkt.packet_valid = 1'b1;
                    pkt.valid_mask   = '1;
                    for (int i = 0; i < `IFB_LANES; i++) begin
                        pkt.data[i] = b;
                        b++;
                    end
                    send_packet(pkt);
                end
            end
            default: begin
                $display("unknown command %h in the vector file", v[79:72]);
                stop_run();
            end
        endcase
    endtask

    initial begin
        loaded = 1'b0;
        wait (loaded);
        #(nlines * LINE_CYCLES * CLK_PERIOD);
        $display("timeout, the DUT did not finish the vectors in time");
        stop_run();
    end

    initial begin
        clk               = 1'b0;
        rst_n             = 1'b0;
        start             = 1'b0;
        start_layer       = 1'b0;
        layer_type_in     = LAYER_NONE;
        packet            = '0;
        decompressor_ack  = 1'b0;
        free_ifmap_buffer = 1'b0;
        seed              = 32'h263a;
        stall_en          = 1'b0;
        last_img          = '0;
        // lines past the end of the file keep command 00
        for (int n = 0; n < MAX_LINES; n++) begin
            vec[n] = '0;
        end
        $readmemh("verification/ifmap_vectors.txt", vec);
        nlines = 0;
        while (nlines < MAX_LINES && vec[nlines][79:72] != 8'h00) begin
            nlines++;
        end
        loaded = 1'b1;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        for (int n = 0; n < nlines; n++) begin
            run_line(vec[n]);
        end
        $display("Verification passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== hdl/ifmap_buffer.sv ====
`timescale 1ns/10ps
`default_nettype none

module ifmap_buffer import ifmap_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start,
    input  wire               start_layer,
    input  wire layer_type_t  layer_type_in,
    input  wire fifo_packet_t packet,
    input  wire               decompressor_ack,
    input  wire               free_ifmap_buffer,
    output logic              ifmap_buffer_req,
    output ifmap_image_t      ifmap_data,
    output logic              ifmap_data_valid,
    output logic              ifmap_data_change
);

    layer_shape_t shape;
    lane_plan_t   plan;
    bank_sel_t    ready;
    bank_sel_t    write_sel;
    bank_sel_t    free_sel;
    ifmap_image_t bank0_image;
    ifmap_image_t bank1_image;

    packet_decoder packet_decoder_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .start_layer   (start_layer),
        .layer_type_in (layer_type_in),
        .packet        (packet),
        .shape         (shape),
        .plan          (plan)
    );

    // ping-pong storage, written from the packet and read by the sequencer
    bank_store bank_store_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start       (start),
        .shape       (shape),
        .plan        (plan),
        .packet      (packet),
        .write_sel   (write_sel),
        .free_sel    (free_sel),
        .ready       (ready),
        .bank0_image (bank0_image),
        .bank1_image (bank1_image)
    );

    bank_sequencer bank_sequencer_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .start             (start),
        .ready             (ready),
        .free_ifmap_buffer (free_ifmap_buffer),
        .decompressor_ack  (decompressor_ack),
        .bank0_image       (bank0_image),
        .bank1_image       (bank1_image),
        .ifmap_buffer_req  (ifmap_buffer_req),
        .write_sel         (write_sel),
        .free_sel          (free_sel),
        .ifmap_data        (ifmap_data),
        .ifmap_data_valid  (ifmap_data_valid),
        .ifmap_data_change (ifmap_data_change)
    );

endmodule

`default_nettype wire

// ==== hdl/bank_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module bank_sequencer import ifmap_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start,
    input  wire bank_sel_t    ready,
    input  wire               free_ifmap_buffer,
    input  wire               decompressor_ack,
    input  wire ifmap_image_t bank0_image,
    input  wire ifmap_image_t bank1_image,
    output logic              ifmap_buffer_req,
    output bank_sel_t         write_sel,
    output bank_sel_t         free_sel,
    output ifmap_image_t      ifmap_data,
    output logic              ifmap_data_valid,
    output logic              ifmap_data_change
);

    bank_sel_t enq_sel;
    bank_sel_t deq_sel;
    bank_sel_t deq_sel_q;
    logic      handshake;

    // fill bank: none while both are full, otherwise the one not ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            enq_sel <= '0;
        end else if (start) begin
            enq_sel <= 2'b01;
        end else if (&ready) begin
            enq_sel <= '0;
        end else if (ready == '0) begin
            // a bank already filling keeps going after the other is freed
            enq_sel <= (enq_sel == '0) ? 2'b01 : enq_sel;
        end else begin
            enq_sel <= ~ready;
        end
    end

    // read bank follows a single ready bank and holds while both are ready
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deq_sel <= '0;
        end else if (start || ready == '0) begin
            deq_sel <= '0;
        end else if (^ready) begin
            deq_sel <= ready;
        end
    end

    // only a full bank that is being read can be freed
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_sel <= '0;
        end else if (start) begin
            free_sel <= '0;
        end else if (free_ifmap_buffer) begin
            free_sel <= ready & deq_sel;
        end else begin
            free_sel <= '0;
        end
    end

    // stall input during the free cycle so the overlap copy has the bank alone
    assign ifmap_buffer_req = (|(enq_sel & ~ready)) & !(|free_sel);
    assign handshake        = ifmap_buffer_req & decompressor_ack;
    assign write_sel        = enq_sel & {2{handshake}};

    always_comb begin
        case (deq_sel)
            2'b01:   ifmap_data = bank0_image;
            2'b10:   ifmap_data = bank1_image;
            default: ifmap_data = '0;
        endcase
    end

    assign ifmap_data_valid = |deq_sel;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deq_sel_q <= '0;
        end else begin
            deq_sel_q <= deq_sel;
        end
    end

    assign ifmap_data_change = (deq_sel != deq_sel_q) & ifmap_data_valid;

    a_sel_not_both_hot: assert property (@(posedge clk) disable iff (!rst_n)
        !(&enq_sel) && !(&deq_sel))
        else $error("fill or read select names both banks");

    // one cycle after ready settles the fill select must have moved off the full bank
    a_fill_not_ready: assert property (@(posedge clk) disable iff (!rst_n)
        ((^ready) && $stable(ready)) |-> !(|(enq_sel & ready)))
        else $error("fill select names a ready bank");

endmodule

`default_nettype wire

// ==== hdl/bank_store.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ifmap_config.svh"

module bank_store import ifmap_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start,
    input  wire layer_shape_t shape,
    input  wire lane_plan_t   plan,
    input  wire fifo_packet_t packet,
    input  wire bank_sel_t    write_sel,
    input  wire bank_sel_t    free_sel,
    output bank_sel_t         ready,
    output ifmap_image_t      bank0_image,
    output ifmap_image_t      bank1_image
);

    localparam int ROW_IDX_W = $clog2(`IFB_MAX_ROWS);

    // position split into whole rows crossed and the column left over
    typedef struct packed {
        logic [2:0]            off;
        logic [`IFB_PTR_W-1:0] col;
    } split_t;

    ifmap_image_t          mem      [2];
    logic [`IFB_PTR_W-1:0] row_ptr  [2];
    logic [`IFB_PTR_W-1:0] elem_ptr [2];

    bank_sel_t             wen;
    split_t                step     [2];
    logic [`IFB_PTR_W:0]   row_sum  [2];
    split_t                lane_pos [2][`IFB_LANES];
    logic [`IFB_PTR_W:0]   tgt_row  [2][`IFB_LANES];
    logic [`IFB_LANES-1:0] lane_hit [2];
    logic [`IFB_LANES-1:0] lane_valid;
    logic [`IFB_PTR_W-1:0] src_row  [`IFB_MAX_ROWS];

    // a packet may cross more than one short row, so subtract the length repeatedly
    function automatic split_t split_pos(input logic [`IFB_PTR_W:0]   pos,
                                         input logic [`IFB_PTR_W-1:0] len);
        split_t              r;
        logic [`IFB_PTR_W:0] rem;
        rem   = pos;
        r.off = '0;
        for (int k = 0; k < 3; k++) begin
            if (len != '0 && rem >= {1'b0, len}) begin
                rem   = rem - {1'b0, len};
                r.off = r.off + 3'd1;
            end
        end
        r.col = rem[`IFB_PTR_W-1:0];
        return r;
    endfunction

    assign lane_valid = packet.valid_mask & {`IFB_LANES{packet.packet_valid}};

    always_comb begin
        for (int b = 0; b < 2; b++) begin
            ready[b]   = (row_ptr[b] == shape.rows);
            wen[b]     = write_sel[b] & ~ready[b];
            step[b]    = split_pos({1'b0, elem_ptr[b]} + {1'b0, plan.count}, shape.elems);
            row_sum[b] = {1'b0, row_ptr[b]} + {2'b00, step[b].off};
            // each valid lane lands at its rank past the element pointer
            for (int i = 0; i < `IFB_LANES; i++) begin
                lane_pos[b][i] = split_pos({1'b0, elem_ptr[b]} + {1'b0, plan.slot[i]},
                                           shape.elems);
                tgt_row[b][i]  = {1'b0, row_ptr[b]} + {2'b00, lane_pos[b][i].off};
                lane_hit[b][i] = lane_valid[i]
                               && (tgt_row[b][i] < {1'b0, shape.rows})
                               && (lane_pos[b][i].col < shape.elems);
            end
        end
        // last overlap rows of a full bank
        for (int r = 0; r < `IFB_MAX_ROWS; r++) begin
            src_row[r] = shape.rows - shape.overlap + r[`IFB_PTR_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int b = 0; b < 2; b++) begin
                elem_ptr[b] <= '0;
                row_ptr[b]  <= '0;
            end
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (start) begin
                    elem_ptr[b] <= '0;
                    // bank 1 waits for the overlap rows of bank 0
                    row_ptr[b]  <= (b == 0) ? '0 : shape.overlap;
                end else if (free_sel[b]) begin
                    elem_ptr[b] <= '0;
                    row_ptr[b]  <= shape.overlap;
                end else if (wen[b]) begin
                    elem_ptr[b] <= step[b].col;
                    row_ptr[b]  <= (row_sum[b] > {1'b0, shape.rows}) ?
                                   shape.rows : row_sum[b][`IFB_PTR_W-1:0];
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem[0] <= '0;
            mem[1] <= '0;
        end else begin
            for (int b = 0; b < 2; b++) begin
                if (start || free_sel[b]) begin
                    mem[b] <= '0;
                end else if (free_sel[1-b]) begin
                    // sliding-window overlap from the bank being freed
                    for (int r = 0; r < `IFB_MAX_ROWS; r++) begin
                        if (r < shape.overlap && src_row[r] < `IFB_MAX_ROWS) begin
                            mem[b][r] <= mem[1-b][src_row[r][ROW_IDX_W-1:0]];
                        end
                    end
                end else if (wen[b]) begin
                    for (int i = 0; i < `IFB_LANES; i++) begin
                        if (lane_hit[b][i]) begin
                            mem[b][tgt_row[b][i][ROW_IDX_W-1:0]][lane_pos[b][i].col] <=
                                packet.data[i];
                        end
                    end
                end
            end
        end
    end

    assign bank0_image = mem[0];
    assign bank1_image = mem[1];

    for (genvar b = 0; b < 2; b++) begin : g_chk
        a_elem_ptr_in_row: assert property (@(posedge clk) disable iff (!rst_n)
            (shape.elems != '0) |-> (elem_ptr[b] < shape.elems))
            else $error("bank %0d element pointer reached the row length", b);
    end

endmodule

`default_nettype wire

// ==== hdl/packet_decoder.sv ====
`timescale 1ns/10ps
`default_nettype none
`include "ifmap_config.svh"

module packet_decoder import ifmap_pkg::*; (
    input  wire               clk,
    input  wire               rst_n,
    input  wire               start_layer,
    input  wire layer_type_t  layer_type_in,
    input  wire fifo_packet_t packet,
    output layer_shape_t      shape,
    output lane_plan_t        plan
);

    layer_type_t           layer_type;
    logic [`IFB_LANES-1:0] lane_valid;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            layer_type <= LAYER_NONE;
        end else if (start_layer) begin
            layer_type <= layer_type_in;
        end
    end

    // shape lookup, an unknown layer leaves the banks with zero size
    always_comb begin
        case (layer_type)
            LAYER_CONV1: begin
                shape.rows    = `IFB_CONV1_ROWS;
                shape.elems   = `IFB_CONV1_ELEMS;
                shape.overlap = `IFB_CONV1_OVERLAP;
            end
            LAYER_CONV2: begin
                shape.rows    = `IFB_CONV2_ROWS;
                shape.elems   = `IFB_CONV2_ELEMS;
                shape.overlap = `IFB_CONV2_OVERLAP;
            end
            default: begin
                shape = '0;
            end
        endcase
    end

    // a packet without packet_valid contributes no lanes
    assign lane_valid = packet.valid_mask & {`IFB_LANES{packet.packet_valid}};

    // running popcount gives every lane its rank and the total at the end
    always_comb begin : rank_calc
        logic [`IFB_PTR_W-1:0] rank;
        rank = '0;
        for (int i = 0; i < `IFB_LANES; i++) begin
            plan.slot[i] = rank;
            rank = rank + {{(`IFB_PTR_W-1){1'b0}}, lane_valid[i]};
        end
        plan.count = rank;
    end

endmodule

`default_nettype wire

// ==== hdl/ifmap_pkg.sv ====
`default_nettype none
`include "ifmap_config.svh"

package ifmap_pkg;

    typedef enum logic [1:0] {
        LAYER_NONE  = 2'd0,
        LAYER_CONV1 = 2'd1,
        LAYER_CONV2 = 2'd2
    } layer_type_t;

    // one packet as delivered by the decompressor
    typedef struct packed {
        logic                                   packet_valid;
        logic [`IFB_LANES-1:0]                  valid_mask;
        logic [`IFB_LANES-1:0][`IFB_ELEM_W-1:0] data;
    } fifo_packet_t;

    typedef struct packed {
        logic [`IFB_PTR_W-1:0] rows;
        logic [`IFB_PTR_W-1:0] elems;
        logic [`IFB_PTR_W-1:0] overlap;
    } layer_shape_t;

    // slot is the rank of a lane among the valid lanes below it
    typedef struct packed {
        logic [`IFB_PTR_W-1:0]                 count;
        logic [`IFB_LANES-1:0][`IFB_PTR_W-1:0] slot;
    } lane_plan_t;

    typedef logic [`IFB_MAX_ROWS-1:0][`IFB_MAX_ELEMS-1:0][`IFB_ELEM_W-1:0] ifmap_image_t;

    // bit 0 is bank 0, bit 1 is bank 1
    typedef logic [1:0] bank_sel_t;

endpackage

`default_nettype wire

// ==== hdl/ifmap_config.svh ====
`ifndef IFMAP_CONFIG_SVH
`define IFMAP_CONFIG_SVH

// packet geometry from the decompressor
`define IFB_LANES       8
`define IFB_ELEM_W      8

// bank geometry, sized for the largest layer
`define IFB_MAX_ROWS    8
`define IFB_MAX_ELEMS   12

// width of row and element pointers, lane counts and ranks
`define IFB_PTR_W       4

// conv1 shape
`define IFB_CONV1_ROWS      4'd8
`define IFB_CONV1_ELEMS     4'd12
`define IFB_CONV1_OVERLAP   4'd2

// conv2 shape, no sliding-window overlap
`define IFB_CONV2_ROWS      4'd4
`define IFB_CONV2_ELEMS     4'd6
`define IFB_CONV2_OVERLAP   4'd0

`endif
